// ==== hw/cu_pkg.sv ====
package cu_pkg;

    // Primary opcodes
    typedef enum logic [5:0] {
        R_TYPE = 6'h00,
        J      = 6'h02,
        JAL    = 6'h03,
        BEQ    = 6'h04,
        BNE    = 6'h05,
        BLE    = 6'h06,
        BGT    = 6'h07,
        ADDI   = 6'h08,
        ADDIU  = 6'h09,
        SLTI   = 6'h0a,
        LW     = 6'h23,
        SW     = 6'h2b
    } opcode_e;

    // R-type function field
    typedef enum logic [5:0] {
        JR   = 6'h08,
        MFHI = 6'h10,
        MFLO = 6'h12,
        MULT = 6'h18,
        DIV  = 6'h1a,
        ADD  = 6'h20,
        SUB  = 6'h22,
        AND  = 6'h24,
        SLT  = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        CL_ALU_R, CL_ALU_I, CL_BRANCH, CL_J, CL_JAL, CL_JR,
        CL_LOAD, CL_STORE, CL_MULDIV, CL_MFHILO, CL_ILLEGAL
    } instr_class_e;

    typedef enum logic [4:0] {
        FETCH1, FETCH2, DECODE,
        EXEC_R, EXEC_I, WB_ALU,
        BRANCH, JUMP, LINK, JUMP_REG,
        MEM_ADDR, MEM_READ, MEM_WAIT, MDR_LOAD, WB_MEM, MEM_WRITE,
        MD_START, MD_WAIT, MD_SAVE, WB_HILO,
        EXC_EPC, EXC_READ, EXC_WAIT, EXC_LOAD, EXC_JUMP
    } state_e;

    typedef enum logic [2:0] {
        ALU_PASS = 3'b000,
        ALU_ADD  = 3'b001,
        ALU_SUB  = 3'b010,
        ALU_AND  = 3'b011,
        ALU_CMP  = 3'b111  // Compare, drives lt/eq/gt flags
    } alu_op_e;

    typedef enum logic [1:0] {BR_EQ, BR_NE, BR_GT, BR_LE} branch_op_e;

    // Datapath mux selects
    typedef enum logic [2:0] {
        PC_ALU = 3'd0, PC_ALUOUT = 3'd1, PC_JUMP = 3'd2, PC_EXC = 3'd6
    } pc_src_e;
    typedef enum logic [2:0] {
        ADDR_PC = 3'd0, ADDR_ALUOUT = 3'd1, ADDR_EXC_ILLEGAL = 3'd2, ADDR_EXC_DIVZERO = 3'd4
    } iord_e;
    typedef enum logic [2:0] {DST_RT = 3'd0, DST_RA = 3'd2, DST_RD = 3'd3} reg_dst_e;
    typedef enum logic [3:0] {
        WB_ALUOUT = 4'd0, WB_MDR = 4'd1, WB_HI = 4'd2, WB_LO = 4'd3, WB_LESS = 4'd8
    } mem_to_reg_e;
    typedef enum logic [1:0] {B_REG, B_FOUR, B_IMM, B_BRANCH_OFS} alu_b_e;

    // Sequencer state plus the divide flag of the current instruction
    typedef struct packed {
        state_e state;
        logic   div_pending;
    } seq_state_t;

    typedef struct packed {
        logic        pc_write;
        logic        pc_write_cond;
        logic        mem_write;
        logic        ir_load;
        logic        ab_load;
        logic        aluout_load;
        logic        mdr_load;
        logic        epc_load;
        logic        hilo_load;
        logic        reg_write;
        logic        md_start;       // One-cycle pulse to the mult/div unit
        logic        md_is_div;
        logic        hilo_from_div;
        pc_src_e     pc_source;
        iord_e       iord;
        reg_dst_e    reg_dst;
        mem_to_reg_e mem_to_reg;
        logic        alu_src_a;      // 0 PC, 1 register A
        alu_b_e      alu_src_b;
        alu_op_e     alu_op;
        branch_op_e  branch_op;
    } ctrl_word_t;

endpackage

// ==== hw/instr_decode.sv ====
module instr_decode
    import cu_pkg::*;
(
    input  opcode_e      op,
    input  funct_e       funct,
    output instr_class_e instr_class,
    output logic         is_div
);

    always_comb begin
        case (op)
            R_TYPE: begin
                case (funct)
                    ADD, SUB, AND, SLT: begin
                        instr_class = CL_ALU_R;
                    end
                    JR: begin
                        instr_class = CL_JR;
                    end
                    MULT, DIV: begin
                        instr_class = CL_MULDIV;
                    end
                    MFHI, MFLO: begin
                        instr_class = CL_MFHILO;
                    end
                    default: begin
                        instr_class = CL_ILLEGAL;
                    end
                endcase
            end
            ADDI, ADDIU, SLTI: begin
                instr_class = CL_ALU_I;
            end
            BEQ, BNE, BLE, BGT: begin
                instr_class = CL_BRANCH;
            end
            J: begin
                instr_class = CL_J;
            end
            JAL: begin
                instr_class = CL_JAL;
            end
            LW: begin
                instr_class = CL_LOAD;
            end
            SW: begin
                instr_class = CL_STORE;
            end
            default: begin
                instr_class = CL_ILLEGAL;  // Unlisted opcode
            end
        endcase
    end

    // Only true for a real div, never for an illegal code
    assign is_div = (op == R_TYPE) && (funct == DIV);

endmodule

// ==== hw/state_seq.sv ====
module state_seq
    import cu_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  instr_class_e instr_class,
    input  logic         is_div,
    input  logic         div_zero,
    input  logic         md_done,
    output seq_state_t   state
);

    state_e next_state;
    logic   next_div;

    always_comb begin
        next_state = FETCH1;
        next_div   = state.div_pending;
        case (state.state)
            FETCH1: next_state = FETCH2;
            FETCH2: next_state = DECODE;
            DECODE: begin
                next_div = is_div;  // Latched once per instruction
                case (instr_class)
                    CL_ALU_R:   next_state = EXEC_R;
                    CL_ALU_I:   next_state = EXEC_I;
                    CL_BRANCH:  next_state = BRANCH;
                    CL_J:       next_state = JUMP;
                    CL_JAL:     next_state = LINK;
                    CL_JR:      next_state = JUMP_REG;
                    CL_LOAD:    next_state = MEM_ADDR;
                    CL_STORE:   next_state = MEM_ADDR;
                    CL_MULDIV:  next_state = MD_START;
                    CL_MFHILO:  next_state = WB_HILO;
                    default:    next_state = EXC_EPC;
                endcase
            end
            EXEC_R:   next_state = WB_ALU;
            EXEC_I:   next_state = WB_ALU;
            LINK:     next_state = JUMP;
            MEM_ADDR: begin
                if (instr_class == CL_STORE) begin
                    next_state = MEM_WRITE;
                end else begin
                    next_state = MEM_READ;
                end
            end
            MEM_READ:  next_state = MEM_WAIT;
            MEM_WRITE: next_state = MEM_WAIT;
            MEM_WAIT: begin
                // Store ends here, load still has to capture the data
                if (instr_class == CL_LOAD) begin
                    next_state = MDR_LOAD;
                end else begin
                    next_state = FETCH1;
                end
            end
            MDR_LOAD: next_state = WB_MEM;
            MD_START: next_state = MD_WAIT;
            MD_WAIT: begin
                if (state.div_pending && div_zero) begin
                    next_state = EXC_EPC;
                end else if (md_done) begin
                    next_state = MD_SAVE;
                end else begin
                    next_state = MD_WAIT;
                end
            end
            EXC_EPC:  next_state = EXC_READ;
            EXC_READ: next_state = EXC_WAIT;
            EXC_WAIT: next_state = EXC_LOAD;  // Memory latency
            EXC_LOAD: next_state = EXC_JUMP;
            // WB_ALU, BRANCH, JUMP, JUMP_REG, WB_MEM, MD_SAVE, WB_HILO, EXC_JUMP
            default:  next_state = FETCH1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state.state       <= FETCH1;
            state.div_pending <= 1'b0;
        end else begin
            state.state       <= next_state;
            state.div_pending <= next_div;
        end
    end

endmodule

// ==== hw/ctrl_decode.sv ====
module ctrl_decode
    import cu_pkg::*;
(
    input  seq_state_t   st,
    input  instr_class_e instr_class,
    input  funct_e       funct,
    input  opcode_e      op,
    output ctrl_word_t   ctrl
);

    logic is_less;

    // slt and slti write back the compare result
    assign is_less = (instr_class == CL_ALU_R && funct == SLT) ||
                     (instr_class == CL_ALU_I && op == SLTI);

    always_comb begin
        ctrl = '0;
        case (st.state)
            FETCH1: begin
                ctrl.iord = ADDR_PC;
            end
            FETCH2: begin
                ctrl.ir_load   = 1'b1;
                ctrl.pc_write  = 1'b1;
                ctrl.pc_source = PC_ALU;
                ctrl.alu_src_b = B_FOUR;
                ctrl.alu_op    = ALU_ADD;  // PC + 4
            end
            DECODE: begin
                ctrl.ab_load     = 1'b1;
                ctrl.aluout_load = 1'b1;
                ctrl.alu_src_b   = B_BRANCH_OFS;  // Branch target ahead of time
                ctrl.alu_op      = ALU_ADD;
            end
            EXEC_R: begin
                ctrl.aluout_load = 1'b1;
                ctrl.alu_src_a   = 1'b1;
                ctrl.alu_src_b   = B_REG;
                case (funct)
                    SUB:     ctrl.alu_op = ALU_SUB;
                    AND:     ctrl.alu_op = ALU_AND;
                    SLT:     ctrl.alu_op = ALU_CMP;
                    default: ctrl.alu_op = ALU_ADD;
                endcase
            end
            EXEC_I: begin
                ctrl.aluout_load = 1'b1;
                ctrl.alu_src_a   = 1'b1;
                ctrl.alu_src_b   = B_IMM;
                ctrl.alu_op      = (op == SLTI) ? ALU_CMP : ALU_ADD;
            end
            WB_ALU: begin
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst    = (instr_class == CL_ALU_R) ? DST_RD : DST_RT;
                ctrl.mem_to_reg = is_less ? WB_LESS : WB_ALUOUT;
            end
            BRANCH: begin
                ctrl.pc_write_cond = 1'b1;
                ctrl.pc_source     = PC_ALUOUT;
                ctrl.alu_src_a     = 1'b1;
                ctrl.alu_src_b     = B_REG;
                ctrl.alu_op        = ALU_CMP;
                case (op)
                    BNE:     ctrl.branch_op = BR_NE;
                    BGT:     ctrl.branch_op = BR_GT;
                    BLE:     ctrl.branch_op = BR_LE;
                    default: ctrl.branch_op = BR_EQ;
                endcase
            end
            JUMP: begin
                ctrl.pc_write  = 1'b1;
                ctrl.pc_source = PC_JUMP;
            end
            LINK: begin
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst    = DST_RA;
                ctrl.mem_to_reg = WB_ALUOUT;
                ctrl.alu_op     = ALU_PASS;  // Return address from PC
            end
            JUMP_REG: begin
                ctrl.pc_write  = 1'b1;
                ctrl.pc_source = PC_ALU;
                ctrl.alu_src_a = 1'b1;
                ctrl.alu_op    = ALU_PASS;
            end
            MEM_ADDR: begin
                ctrl.aluout_load = 1'b1;
                ctrl.alu_src_a   = 1'b1;
                ctrl.alu_src_b   = B_IMM;
                ctrl.alu_op      = ALU_ADD;
            end
            MEM_READ, MEM_WAIT: ctrl.iord = ADDR_ALUOUT;
            MEM_WRITE: begin
                ctrl.iord      = ADDR_ALUOUT;
                ctrl.mem_write = 1'b1;
            end
            MDR_LOAD: ctrl.mdr_load = 1'b1;
            WB_MEM: begin
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst    = DST_RT;
                ctrl.mem_to_reg = WB_MDR;
            end
            MD_START: begin
                ctrl.md_start  = 1'b1;
                ctrl.md_is_div = st.div_pending;
            end
            MD_WAIT: ctrl.md_is_div = st.div_pending;
            MD_SAVE: begin
                ctrl.hilo_load     = 1'b1;
                ctrl.hilo_from_div = st.div_pending;
            end
            WB_HILO: begin
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst    = DST_RD;
                ctrl.mem_to_reg = (funct == MFHI) ? WB_HI : WB_LO;
            end
            EXC_EPC: begin
                ctrl.epc_load  = 1'b1;
                ctrl.alu_src_b = B_FOUR;
                ctrl.alu_op    = ALU_SUB;  // Back to the faulting instruction
            end
            EXC_READ, EXC_WAIT: begin
                ctrl.iord = st.div_pending ? ADDR_EXC_DIVZERO : ADDR_EXC_ILLEGAL;
            end
            EXC_LOAD: begin
                ctrl.mdr_load  = 1'b1;
                ctrl.pc_source = PC_EXC;
            end
            EXC_JUMP: begin
                ctrl.pc_write  = 1'b1;
                ctrl.pc_source = PC_EXC;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// ==== hw/control_unit.sv ====
module control_unit
    import cu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  opcode_e    op,
    input  funct_e     funct,
    input  logic       div_zero,
    input  logic       md_done,
    output ctrl_word_t ctrl
);

    instr_class_e instr_class;
    logic         is_div;
    seq_state_t   st;

    instr_decode u_instr_decode (
        .op          (op),
        .funct       (funct),
        .instr_class (instr_class),
        .is_div      (is_div)
    );

    state_seq u_state_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_class (instr_class),
        .is_div      (is_div),
        .div_zero    (div_zero),
        .md_done     (md_done),
        .state       (st)
    );

    ctrl_decode u_ctrl_decode (
        .st          (st),
        .instr_class (instr_class),
        .funct       (funct),
        .op          (op),
        .ctrl        (ctrl)
    );

endmodule

// ==== bench/tb_clock.sv ====
module tb_clock (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // Reset held over the first 10 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== bench/tb_control_unit.sv ====
module tb_control_unit
    import cu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int      NROWS  = 24;
    localparam logic    N      = 1'b0;
    localparam logic    Y      = 1'b1;
    localparam opcode_e OP_BAD = opcode_e'(6'h3f);
    localparam funct_e  FN_BAD = funct_e'(6'h01);

    typedef struct packed {
        opcode_e     op;
        funct_e      funct;
        logic        divz;     // div_zero level for the whole instruction
        logic        delayed;  // md_done held low a random number of cycles
        int          len;      // Length without the md delay
        int          n_wb;
        reg_dst_e    dst;
        mem_to_reg_e m2r;
        int          n_pcw;
        int          n_pcc;
        int          n_memw;
        int          n_epc;
        int          n_hilo;
        pc_src_e     jsrc;     // Source of the pc_write after FETCH2
        iord_e       vec;
    } row_t;

    // op, funct, div_zero, delay, length, reg_write, reg_dst, mem_to_reg,
    // counts of pc_write, pc_write_cond, mem_write, epc_load, hilo_load, jump source, vector
    row_t row_table [NROWS] = '{
        '{R_TYPE, ADD,    N, N, 5,  1, DST_RD, WB_ALUOUT, 1, 0, 0, 0, 0, PC_ALU,  ADDR_PC},
        '{R_TYPE, SUB,    N, N, 5,  1, DST_RD, WB_ALUOUT, 1, 0, 0, 0, 0, PC_ALU,  ADDR_PC},
        '{R_TYPE, AND,    N, N, 5,  1, DST_RD, WB_ALUOUT, 1, 0, 0, 0, 0, PC_ALU,  ADDR_PC},
        '{R_TYPE, SLT,    N, N, 5,  1, DST_RD, WB_LESS,   1, 0, 0, 0, 0, PC_ALU,  ADDR_PC},
        '{ADDI,   ADD,    N, N, 5,  1, DST_RT, WB_ALUOUT, 1, 0, 0, 0, 0, PC_ALU,  ADDR_PC},
        '{ADDIU,  ADD,    N, N, 5,  1, DST_RT, WB_ALUOUT, 1, 0, 0, 0, 0, PC_ALU,  ADDR_PC},
        '{SLTI,   ADD,    N, N, 5,  1, DST_RT, WB_LESS,   1, 0, 0, 0, 0, PC_ALU,  ADDR_PC},
        '{BEQ,    ADD,    N, N, 4,  0, DST_RT, WB_ALUOUT, 1, 1, 0, 0, 0, PC_ALU,  ADDR_PC},
        '{BNE,    ADD,    N, N, 4,  0, DST_RT, WB_ALUOUT, 1, 1, 0, 0, 0, PC_ALU,  ADDR_PC},
        '{BLE,    ADD,    N, N, 4,  0, DST_RT, WB_ALUOUT, 1, 1, 0, 0, 0, PC_ALU,  ADDR_PC},
        '{BGT,    ADD,    N, N, 4,  0, DST_RT, WB_ALUOUT, 1, 1, 0, 0, 0, PC_ALU,  ADDR_PC},
        '{J,      ADD,    N, N, 4,  0, DST_RT, WB_ALUOUT, 2, 0, 0, 0, 0, PC_JUMP, ADDR_PC},
        '{R_TYPE, JR,     N, N, 4,  0, DST_RT, WB_ALUOUT, 2, 0, 0, 0, 0, PC_ALU,  ADDR_PC},
        '{JAL,    ADD,    N, N, 5,  1, DST_RA, WB_ALUOUT, 2, 0, 0, 0, 0, PC_JUMP, ADDR_PC},
        '{LW,     ADD,    N, N, 8,  1, DST_RT, WB_MDR,    1, 0, 0, 0, 0, PC_ALU,  ADDR_PC},
        '{SW,     ADD,    N, N, 6,  0, DST_RT, WB_ALUOUT, 1, 0, 1, 0, 0, PC_ALU,  ADDR_PC},
        '{R_TYPE, MULT,   N, Y, 6,  0, DST_RT, WB_ALUOUT, 1, 0, 0, 0, 1, PC_ALU,  ADDR_PC},
        '{R_TYPE, MFHI,   N, N, 4,  1, DST_RD, WB_HI,     1, 0, 0, 0, 0, PC_ALU,  ADDR_PC},
        '{R_TYPE, DIV,    N, Y, 6,  0, DST_RT, WB_ALUOUT, 1, 0, 0, 0, 1, PC_ALU,  ADDR_PC},
        '{R_TYPE, MFLO,   N, N, 4,  1, DST_RD, WB_LO,     1, 0, 0, 0, 0, PC_ALU,  ADDR_PC},
        '{R_TYPE, MULT,   Y, Y, 6,  0, DST_RT, WB_ALUOUT, 1, 0, 0, 0, 1, PC_ALU,  ADDR_PC},
        '{R_TYPE, DIV,    Y, N, 10, 0, DST_RT, WB_ALUOUT, 2, 0, 0, 1, 0, PC_EXC,
          ADDR_EXC_DIVZERO},
        '{OP_BAD, ADD,    N, N, 8,  0, DST_RT, WB_ALUOUT, 2, 0, 0, 1, 0, PC_EXC,
          ADDR_EXC_ILLEGAL},
        '{R_TYPE, FN_BAD, N, N, 8,  0, DST_RT, WB_ALUOUT, 2, 0, 0, 1, 0, PC_EXC,
          ADDR_EXC_ILLEGAL}
    };

    logic       clk;
    logic       rst_n;
    opcode_e    op;
    funct_e     funct;
    logic       div_zero;
    logic       md_done;
    ctrl_word_t ctrl;

    ctrl_word_t trace[$];  // One control word per cycle, from FETCH1 on
    int         seed = 32'h701e;
    int         cur_row = 0;

    tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    control_unit dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .op       (op),
        .funct    (funct),
        .div_zero (div_zero),
        .md_done  (md_done),
        .ctrl     (ctrl)
    );

    function automatic logic [10:0] enables(input ctrl_word_t c);
        return {c.pc_write, c.pc_write_cond, c.mem_write, c.ir_load, c.ab_load,
                c.aluout_load, c.mdr_load, c.epc_load, c.hilo_load, c.reg_write, c.md_start};
    endfunction

    function automatic branch_op_e expected_branch(input opcode_e o);
        case (o)
            BNE:     return BR_NE;
            BGT:     return BR_GT;
            BLE:     return BR_LE;
            default: return BR_EQ;
        endcase
    endfunction

    task automatic check_val(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("ERR %0t row %0d %s: got %0d, expected %0d",
                     $time, cur_row, name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic report_hang(input string what);
        $display("Timeout: no %s within 64 cycles (row %0d)", what, cur_row);
        $display("Finished with errors");
        $fatal(1, "hang");
    endtask

    task automatic apply_row(input int r);
        op       <= row_table[r].op;
        funct    <= row_table[r].funct;
        div_zero <= row_table[r].divz;
        md_done  <= 1'b0;
    endtask

    task automatic wait_reset_release();
        int guard;
        guard = 0;
        @(posedge clk);
        @(negedge clk);
        while (!rst_n) begin
            if (guard == 64) begin
                report_hang("reset release");
            end
            check_val("enables in reset", int'(enables(ctrl)), 0);
            guard++;
            @(negedge clk);
        end
    endtask

    task automatic check_row(input int r, input int delay);
        row_t       w;
        ctrl_word_t c;
        logic       is_div;
        logic       is_md;
        int         len;
        int         n_pcw, n_pcc, n_memw, n_epc, n_hilo, n_wb, n_md, n_mdr;
        w = row_table[r];
        is_div = (w.op == R_TYPE) && (w.funct == DIV);
        is_md = (w.op == R_TYPE) && (w.funct == MULT || w.funct == DIV);
        len = trace.size() - 2;  // Last two entries open the next instruction
        n_pcw = 0;
        n_pcc = 0;
        n_memw = 0;
        n_epc = 0;
        n_hilo = 0;
        n_wb = 0;
        n_md = 0;
        n_mdr = 0;
        check_val("length", len, w.len + delay);
        check_val("enables in FETCH1", int'(enables(trace[0])), 0);
        check_val("ir_load in FETCH2", int'(trace[1].ir_load), 1);
        check_val("pc_write in FETCH2", int'(trace[1].pc_write), 1);
        check_val("alu_src_b in FETCH2", int'(trace[1].alu_src_b), int'(B_FOUR));
        check_val("alu_op in FETCH2", int'(trace[1].alu_op), int'(ALU_ADD));
        check_val("ab_load in DECODE", int'(trace[2].ab_load), 1);
        check_val("aluout_load in DECODE", int'(trace[2].aluout_load), 1);
        for (int i = 0; i < len; i++) begin
            c = trace[i];
            if (c.pc_write) begin
                n_pcw++;
                check_val("pc_source", int'(c.pc_source), int'(i == 1 ? PC_ALU : w.jsrc));
            end
            if (c.pc_write_cond) begin
                n_pcc++;
                check_val("branch_op", int'(c.branch_op), int'(expected_branch(w.op)));
                check_val("pc_source at branch", int'(c.pc_source), int'(PC_ALUOUT));
            end
            if (c.mem_write) begin
                n_memw++;
                check_val("iord at mem_write", int'(c.iord), int'(ADDR_ALUOUT));
            end
            if (c.epc_load) begin
                n_epc++;
                check_val("alu_op at epc_load", int'(c.alu_op), int'(ALU_SUB));
                check_val("alu_src_b at epc_load", int'(c.alu_src_b), int'(B_FOUR));
                check_val("iord after epc_load", int'(trace[i + 1].iord), int'(w.vec));
            end
            if (c.mdr_load) begin
                n_mdr++;
            end
            if (c.hilo_load) begin
                n_hilo++;
                check_val("hilo_from_div", int'(c.hilo_from_div), int'(is_div));
            end
            if (c.reg_write) begin
                n_wb++;
                check_val("reg_dst", int'(c.reg_dst), int'(w.dst));
                check_val("mem_to_reg", int'(c.mem_to_reg), int'(w.m2r));
            end
            if (c.md_start) begin
                n_md++;
                check_val("md_is_div", int'(c.md_is_div), int'(is_div));
            end
        end
        check_val("pc_write count", n_pcw, w.n_pcw);
        check_val("pc_write_cond count", n_pcc, w.n_pcc);
        check_val("mem_write count", n_memw, w.n_memw);
        check_val("epc_load count", n_epc, w.n_epc);
        check_val("hilo_load count", n_hilo, w.n_hilo);
        check_val("reg_write count", n_wb, w.n_wb);
        check_val("md_start count", n_md, is_md ? 1 : 0);
        // Load data capture, or the vector fetch of an exception
        check_val("mdr_load count", n_mdr, w.n_epc + (w.m2r == WB_MDR ? 1 : 0));
    endtask

    task automatic run_row(input int r);
        int   delay;
        int   exp_len;
        int   guard;
        int   md_cnt;
        logic md_active;
        logic done;
        cur_row = r;
        delay = 0;
        if (row_table[r].delayed) begin
            delay = $unsigned($random(seed)) % 8;
        end
        exp_len = row_table[r].len + delay;
        guard = 0;
        md_cnt = 0;
        md_active = 1'b0;
        done = 1'b0;
        while (!done) begin
            if (guard == 64) begin
                report_hang("ir_load");
            end
            guard++;
            @(posedge clk);
            if (md_active) begin
                md_done <= (md_cnt >= delay);  // Low for delay cycles after md_start
                md_cnt++;
            end
            if (trace.size() == exp_len && r + 1 < NROWS) begin
                md_active = 1'b0;
                apply_row(r + 1);  // Next FETCH1 starts here
            end
            @(negedge clk);
            trace.push_back(ctrl);
            if (ctrl.md_start) begin
                md_active = 1'b1;
                md_cnt = 0;
            end
            if (trace.size() > 2 && ctrl.ir_load) begin
                done = 1'b1;
            end
        end
        check_row(r, delay);
        for (int i = 0; i < exp_len; i++) begin
            void'(trace.pop_front());
        end
    endtask

    initial begin
        op       = row_table[0].op;
        funct    = row_table[0].funct;
        div_zero = row_table[0].divz;
        md_done  = 1'b0;
        wait_reset_release();
        trace.push_back(ctrl);  // First cycle after reset
        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== flist.f ====
hw/cu_pkg.sv
hw/instr_decode.sv
hw/state_seq.sv
hw/ctrl_decode.sv
hw/control_unit.sv
bench/tb_clock.sv
bench/tb_control_unit.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps -j 0 \
		--top-module tb_control_unit -f flist.f -Mdir obj_dir
	./obj_dir/Vtb_control_unit | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
